//--- alu.sv
module alu (
    input  idu_pkg::alu_op_e         op,
    input  logic [idu_pkg::xlen-1:0] a,
    input  logic [idu_pkg::xlen-1:0] b,
    input  logic [2:0]               funct3,
    output logic [idu_pkg::xlen-1:0] y,
    output logic                     taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            idu_pkg::alu_add:    y = a + b;
            idu_pkg::alu_sub:    y = a - b;
            idu_pkg::alu_sll:    y = a << shamt;
            idu_pkg::alu_slt:    y = {{(idu_pkg::xlen-1){1'b0}}, lt_s};
            idu_pkg::alu_sltu:   y = {{(idu_pkg::xlen-1){1'b0}}, lt_u};
            idu_pkg::alu_xor:    y = a ^ b;
            idu_pkg::alu_srl:    y = a >> shamt;
            idu_pkg::alu_sra:    y = $signed(a) >>> shamt;
            idu_pkg::alu_or:     y = a | b;
            idu_pkg::alu_and:    y = a & b;
            idu_pkg::alu_pass_b: y = b;
            default:             y = '0;
        endcase
    end

    // Branch condition, only meaningful for branch encodings
    always_comb begin
        case (funct3)
            3'b000:  taken = a == b;    // BEQ
            3'b001:  taken = a != b;    // BNE
            3'b100:  taken = lt_s;
            3'b101:  taken = !lt_s;
            3'b110:  taken = lt_u;
            3'b111:  taken = !lt_u;     // BGEU
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- core_top.sv
module core_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     inst_valid,
    input  logic [idu_pkg::xlen-1:0] pc,
    input  logic [31:0]              inst,
    output idu_pkg::result_t         result
);

    idu_pkg::decode_t                 dec;
    logic [idu_pkg::xlen-1:0]         rdata1;
    logic [idu_pkg::xlen-1:0]         rdata2;
    logic                             we;
    logic [idu_pkg::reg_addr_w-1:0]   waddr;
    logic [idu_pkg::xlen-1:0]         wdata;

    idu u_idu (
        .inst (inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clock  (clock),
        .reset  (reset),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exu u_exu (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .pc         (pc),
        .dec        (dec),
        .rs1_data   (rdata1),
        .rs2_data   (rdata2),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .result     (result)
    );

endmodule

//--- exu.sv
module exu (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           inst_valid,
    input  logic [idu_pkg::xlen-1:0]       pc,
    input  idu_pkg::decode_t               dec,
    input  logic [idu_pkg::xlen-1:0]       rs1_data,
    input  logic [idu_pkg::xlen-1:0]       rs2_data,
    output logic                           we,
    output logic [idu_pkg::reg_addr_w-1:0] waddr,
    output logic [idu_pkg::xlen-1:0]       wdata,
    output idu_pkg::result_t               result
);

    idu_pkg::issue_t          iss;
    logic [idu_pkg::xlen-1:0] rs1_fwd;
    logic [idu_pkg::xlen-1:0] rs2_fwd;
    logic [idu_pkg::xlen-1:0] alu_a;
    logic [idu_pkg::xlen-1:0] alu_b;
    logic [idu_pkg::xlen-1:0] alu_y;
    logic [idu_pkg::xlen-1:0] pc_rel;
    logic [idu_pkg::xlen-1:0] target;
    logic                     taken;
    logic                     is_jalr;

    // Bypass the in-flight write, the register file only sees it next edge
    assign rs1_fwd = (we && waddr == dec.rs1) ? wdata : rs1_data;
    assign rs2_fwd = (we && waddr == dec.rs2) ? wdata : rs2_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= inst_valid;
        end
        iss.pc  <= pc;
        iss.dec <= dec;
        iss.rs1 <= rs1_fwd;
        iss.rs2 <= rs2_fwd;
    end

    assign alu_a = (iss.dec.inst_class == idu_pkg::cls_upper) ? iss.pc : iss.rs1;  // AUIPC
    assign alu_b = iss.dec.use_imm ? iss.dec.imm : iss.rs2;

    alu u_alu (
        .op     (iss.dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .funct3 (iss.dec.funct3),
        .y      (alu_y),
        .taken  (taken)
    );

    assign is_jalr = iss.dec.inst_class == idu_pkg::cls_jump && iss.dec.alu_op == idu_pkg::alu_add;
    assign pc_rel  = iss.pc + iss.dec.imm;

    always_comb begin
        wdata  = '0;
        target = '0;
        case (iss.dec.inst_class)
            idu_pkg::cls_alu, idu_pkg::cls_upper, idu_pkg::cls_load, idu_pkg::cls_store:
                wdata = alu_y;
            idu_pkg::cls_jump: begin
                wdata  = iss.pc + 32'd4;
                target = is_jalr ? {alu_y[idu_pkg::xlen-1:1], 1'b0} : pc_rel;
            end
            idu_pkg::cls_branch: target = pc_rel;
            default: ;
        endcase
    end

    assign waddr = iss.dec.rd;
    assign we    = iss.valid && iss.dec.reg_write && iss.dec.rd != '0 &&
                   iss.dec.inst_class inside {idu_pkg::cls_alu, idu_pkg::cls_upper,
                                              idu_pkg::cls_jump};

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid   <= 1'b0;
            result.written <= 1'b0;
        end else begin
            result.valid   <= iss.valid;
            result.written <= we;
        end
        result.pc           <= iss.pc;
        result.inst_class   <= iss.dec.inst_class;
        result.rd           <= iss.dec.rd;
        result.wdata        <= wdata;
        result.branch_taken <= iss.dec.inst_class == idu_pkg::cls_branch && taken;
        result.target       <= target;
        result.csr_addr     <= iss.dec.csr_addr;
        result.invalid      <= iss.dec.invalid;
    end

endmodule

//--- idu.sv
module idu (
    input  logic [31:0]      inst,
    output idu_pkg::decode_t dec
);

    idu_pkg::opcode_e opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [11:0]      funct12;
    logic [31:0]      imm_i;
    logic [31:0]      imm_u;
    logic [31:0]      imm_s;
    logic [31:0]      imm_b;
    logic [31:0]      imm_j;
    logic [31:0]      imm;
    logic             valid_jalr;
    logic             valid_load;
    logic             valid_store;
    logic             valid_branch;
    logic             valid_op_imm;
    logic             valid_op;
    logic             valid_system;
    logic             r_base;
    logic             m_ext;
    logic             legal;
    logic             alt;

    function automatic idu_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt_sel);
        case (f3)
            3'b000:  return alt_sel ? idu_pkg::alu_sub : idu_pkg::alu_add;
            3'b001:  return idu_pkg::alu_sll;
            3'b010:  return idu_pkg::alu_slt;
            3'b011:  return idu_pkg::alu_sltu;
            3'b100:  return idu_pkg::alu_xor;
            3'b101:  return alt_sel ? idu_pkg::alu_sra : idu_pkg::alu_srl;
            3'b110:  return idu_pkg::alu_or;
            default: return idu_pkg::alu_and;
        endcase
    endfunction

    assign opcode  = idu_pkg::opcode_e'(inst[6:0]);
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign funct12 = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    mux_key_default #(
        .nr_key   (idu_pkg::nr_imm_keys),
        .key_len  ($bits(idu_pkg::opcode_e)),
        .data_len (idu_pkg::xlen)
    ) imm_select (
        .key         (opcode),
        .default_out ('0),
        .lut         ({idu_pkg::opc_auipc,  imm_u,
                       idu_pkg::opc_lui,    imm_u,
                       idu_pkg::opc_op_imm, imm_i,
                       idu_pkg::opc_load,   imm_i,
                       idu_pkg::opc_jalr,   imm_i,
                       idu_pkg::opc_store,  imm_s,
                       idu_pkg::opc_jal,    imm_j,
                       idu_pkg::opc_branch, imm_b}),
        .out         (imm)
    );

    assign valid_jalr   = opcode == idu_pkg::opc_jalr && funct3 == 3'b000;
    assign valid_load   = opcode == idu_pkg::opc_load &&
                          funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    assign valid_store  = opcode == idu_pkg::opc_store && funct3 inside {3'b000, 3'b001, 3'b010};
    assign valid_branch = opcode == idu_pkg::opc_branch && funct3 != 3'b010 && funct3 != 3'b011;

    // Shifts constrain funct7, the rest take any immediate
    assign valid_op_imm = opcode == idu_pkg::opc_op_imm &&
                          (funct3 inside {3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111} ||
                           (funct3 == 3'b001 && funct7 == 7'b0000000) ||
                           (funct3 == 3'b101 && funct7 inside {7'b0000000, 7'b0100000}));

    assign r_base   = funct7 == 7'b0000000 ||
                      (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101});  // SUB, SRA
    assign m_ext    = funct7 == 7'b0000001 && funct3 != 3'b010 && funct3 != 3'b011;
    assign valid_op = opcode == idu_pkg::opc_op && (r_base || m_ext);

    assign valid_system = opcode == idu_pkg::opc_system &&
                          ((funct3 == 3'b000 && funct12 inside {12'h000, 12'h001, 12'h302}) ||
                           funct3 inside {3'b001, 3'b010});   // ECALL, EBREAK, MRET, CSRRW, CSRRS

    assign legal = opcode == idu_pkg::opc_lui || opcode == idu_pkg::opc_auipc ||
                   opcode == idu_pkg::opc_jal || valid_jalr || valid_load || valid_store ||
                   valid_branch || valid_op_imm || valid_op || valid_system;

    assign alt = funct7[5] && (opcode == idu_pkg::opc_op || funct3 == 3'b101);

    always_comb begin
        dec.inst_class = idu_pkg::cls_invalid;
        dec.alu_op     = idu_pkg::alu_add;
        dec.use_imm    = 1'b1;
        if (legal) begin
            case (opcode)
                idu_pkg::opc_lui: begin
                    dec.inst_class = idu_pkg::cls_upper;
                    dec.alu_op     = idu_pkg::alu_pass_b;
                end
                idu_pkg::opc_auipc:  dec.inst_class = idu_pkg::cls_upper;
                idu_pkg::opc_jal: begin
                    dec.inst_class = idu_pkg::cls_jump;
                    dec.alu_op     = idu_pkg::alu_pass_b;   // Marks pc-relative jump
                end
                idu_pkg::opc_jalr:   dec.inst_class = idu_pkg::cls_jump;
                idu_pkg::opc_branch: begin
                    dec.inst_class = idu_pkg::cls_branch;
                    dec.use_imm    = 1'b0;
                end
                idu_pkg::opc_load:   dec.inst_class = idu_pkg::cls_load;
                idu_pkg::opc_store:  dec.inst_class = idu_pkg::cls_store;
                idu_pkg::opc_op_imm: begin
                    dec.inst_class = idu_pkg::cls_alu;
                    dec.alu_op     = arith_op(funct3, alt);
                end
                idu_pkg::opc_op: begin
                    dec.inst_class = m_ext ? idu_pkg::cls_muldiv : idu_pkg::cls_alu;
                    dec.alu_op     = arith_op(funct3, alt);
                    dec.use_imm    = 1'b0;
                end
                default:             dec.inst_class = idu_pkg::cls_system;
            endcase
        end
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm;
        dec.reg_write = opcode inside {idu_pkg::opc_lui, idu_pkg::opc_auipc, idu_pkg::opc_jal,
                                       idu_pkg::opc_jalr, idu_pkg::opc_load, idu_pkg::opc_op_imm,
                                       idu_pkg::opc_op, idu_pkg::opc_system};
        dec.funct3    = funct3;
        dec.csr_addr  = valid_system ? funct12 : '0;
        dec.invalid   = !legal;
    end

endmodule

//--- idu_pkg.sv
package idu_pkg;

    localparam int xlen        = 32;
    localparam int nr_regs     = 32;
    localparam int reg_addr_w  = 5;
    localparam int csr_addr_w  = 12;
    localparam int nr_imm_keys = 8;    // Opcodes carrying an immediate

    // RV32 major opcodes
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        cls_alu,
        cls_upper,
        cls_jump,
        cls_branch,
        cls_load,
        cls_store,
        cls_muldiv,
        cls_system,
        cls_invalid
    } inst_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b      // Operand b straight through
    } alu_op_e;

    typedef struct packed {
        inst_class_e           inst_class;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;
        logic                  use_imm;     // Immediate replaces rs2 as operand b
        logic                  reg_write;   // Opcode normally writes rd
        logic [2:0]            funct3;
        logic [csr_addr_w-1:0] csr_addr;
        logic                  invalid;
    } decode_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        decode_t         dec;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        inst_class_e           inst_class;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;       // Also the address of loads and stores
        logic                  written;
        logic                  branch_taken;
        logic [xlen-1:0]       target;
        logic [csr_addr_w-1:0] csr_addr;
        logic                  invalid;
    } result_t;

endpackage

//--- mux_key_default.sv
module mux_key_default #(
    parameter int nr_key   = 2,
    parameter int key_len  = 1,
    parameter int data_len = 1
) (
    input  logic [key_len-1:0]                    key,
    input  logic [data_len-1:0]                   default_out,
    input  logic [nr_key*(key_len+data_len)-1:0]  lut,
    output logic [data_len-1:0]                   out
);

    localparam int pair_len = key_len + data_len;

    logic [key_len-1:0]  lut_key  [nr_key];
    logic [data_len-1:0] lut_data [nr_key];

    // Unpack the flat table, key in the upper bits of each pair
    always_comb begin
        for (int i = 0; i < nr_key; i++) begin
            lut_key[i]  = lut[i*pair_len+data_len +: key_len];
            lut_data[i] = lut[i*pair_len +: data_len];
        end
    end

    always_comb begin
        out = default_out;
        for (int i = 0; i < nr_key; i++) begin
            if (lut_key[i] == key) begin
                out = lut_data[i];
            end
        end
    end

endmodule

//--- regfile.sv
module regfile (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [idu_pkg::reg_addr_w-1:0] raddr1,
    input  logic [idu_pkg::reg_addr_w-1:0] raddr2,
    input  logic                           we,
    input  logic [idu_pkg::reg_addr_w-1:0] waddr,
    input  logic [idu_pkg::xlen-1:0]       wdata,
    output logic [idu_pkg::xlen-1:0]       rdata1,
    output logic [idu_pkg::xlen-1:0]       rdata2
);

    logic [idu_pkg::xlen-1:0] regs [idu_pkg::nr_regs];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < idu_pkg::nr_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // Read ports see the old value during a write cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_core -f tb.f -o tb_core_sim > build.log 2>&1 &&
./obj_dir/tb_core_sim > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb.f
idu_pkg.sv
mux_key_default.sv
idu.sv
regfile.sv
alu.sv
exu.sv
core_top.sv
tb_core.sv

//--- tb_core.sv
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                           idle;
        logic [31:0]                    pc;
        logic [31:0]                    inst;
        idu_pkg::inst_class_e           cls;
        logic [idu_pkg::reg_addr_w-1:0] rd;
        logic [31:0]                    wdata;
        logic                           written;
        logic                           taken;
        logic [31:0]                    target;
        logic                           invalid;
        logic [idu_pkg::csr_addr_w-1:0] csr;
    } row_t;

    logic             clock;
    logic             reset;
    logic             inst_valid;
    logic [31:0]      pc;
    logic [31:0]      inst;
    idu_pkg::result_t result;

    row_t        table_q[$];
    row_t        exp_q[$];
    row_t        exp_row;
    int          seed;
    logic [31:0] rnd;
    logic [31:0] seq_pc;
    int          val_errs;
    int          seq_errs;
    int          res_idx;
    int          cycles;
    int          limit;
    logic        timed_out;

    core_top UUT (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .pc         (pc),
        .inst       (inst),
        .result     (result)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], idu_pkg::opc_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], idu_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, idu_pkg::opc_jal};
    endfunction

    task push_row(input logic idle, input logic [31:0] row_pc, input logic [31:0] row_inst,
                  input idu_pkg::inst_class_e cls, input logic [idu_pkg::reg_addr_w-1:0] rd,
                  input logic [31:0] wdata,
                  input logic written, input logic taken, input logic [31:0] target,
                  input logic invalid, input logic [11:0] csr);
        table_q.push_back('{idle, row_pc, row_inst, cls, rd, wdata, written, taken, target,
                            invalid, csr});
    endtask

    // Straight-line rows, pc advances by 4
    task seq_row(input logic [31:0] row_inst, input idu_pkg::inst_class_e cls,
                 input logic [idu_pkg::reg_addr_w-1:0] rd, input logic [31:0] wdata,
                 input logic written, input logic invalid, input logic [11:0] csr);
        seq_pc = seq_pc + 32'd4;
        push_row(1'b0, seq_pc, row_inst, cls, rd, wdata, written, 1'b0, 32'h0, invalid, csr);
    endtask

    task pick_pc(input logic [31:0] base, output logic [31:0] row_pc);
        rnd    = $random(seed);
        row_pc = base + {20'd0, rnd[9:0], 2'b00};
    endtask

    task jal_row(input int offset);
        logic [31:0] row_pc;
        pick_pc(32'h3000, row_pc);
        push_row(1'b0, row_pc, j_type(offset[20:0], 5'd12), idu_pkg::cls_jump, 5'd12,
                 row_pc + 32'd4, 1'b1, 1'b0, row_pc + offset, 1'b0, 12'h0);
    endtask

    // Base is the known content of x9
    task jalr_row(input logic [11:0] imm, input logic [31:0] base);
        logic [31:0] row_pc;
        pick_pc(32'h3800, row_pc);
        push_row(1'b0, row_pc, i_type(imm, 5'd9, 3'b000, 5'd13, idu_pkg::opc_jalr),
                 idu_pkg::cls_jump, 5'd13, row_pc + 32'd4, 1'b1, 1'b0,
                 (base + {{20{imm[11]}}, imm}) & ~32'd1, 1'b0, 12'h0);
    endtask

    task branch_row(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                    input int offset, input logic taken);
        logic [31:0] row_pc;
        pick_pc(32'h4000, row_pc);
        push_row(1'b0, row_pc, b_type(offset[12:0], rs2, rs1, f3), idu_pkg::cls_branch,
                 5'd0, 32'h0, 1'b0, taken, row_pc + offset, 1'b0, 12'h0);
    endtask

    task push_idle();
        push_row(1'b1, 32'h0, 32'h0, idu_pkg::cls_invalid, 5'd0, 32'h0, 1'b0, 1'b0, 32'h0,
                 1'b0, 12'h0);
    endtask

    task build_table();
        seq_pc = 32'h1000;
        seq_row(i_type(12'hFFB, 5'd0, 3'b000, 5'd1, idu_pkg::opc_op_imm),
                idu_pkg::cls_alu, 5'd1, 32'hFFFF_FFFB, 1'b1, 1'b0, 12'h0);      // x1 = -5
        seq_row(i_type(12'd12, 5'd0, 3'b000, 5'd2, idu_pkg::opc_op_imm),
                idu_pkg::cls_alu, 5'd2, 32'd12, 1'b1, 1'b0, 12'h0);
        seq_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd3, 32'd7, 1'b1, 1'b0, 12'h0);        // Needs x2 forwarded
        seq_row(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd4, 32'd12, 1'b1, 1'b0, 12'h0);
        seq_row(i_type(12'd2, 5'd0, 3'b000, 5'd6, idu_pkg::opc_op_imm),
                idu_pkg::cls_alu, 5'd6, 32'd2, 1'b1, 1'b0, 12'h0);
        seq_row(r_type(7'h20, 5'd6, 5'd1, 3'b101, 5'd5, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd5, 32'hFFFF_FFFE, 1'b1, 1'b0, 12'h0);      // SRA
        seq_row(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd7, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd7, 32'd1, 1'b1, 1'b0, 12'h0);
        seq_row(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd8, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd8, 32'd0, 1'b1, 1'b0, 12'h0);
        seq_row(i_type(12'd99, 5'd0, 3'b000, 5'd0, idu_pkg::opc_op_imm),
                idu_pkg::cls_alu, 5'd0, 32'd99, 1'b0, 1'b0, 12'h0);             // Write to x0
        seq_row(r_type(7'h00, 5'd2, 5'd0, 3'b000, 5'd9, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd9, 32'd12, 1'b1, 1'b0, 12'h0);
        seq_row(u_type(20'h12345, 5'd10, idu_pkg::opc_lui),
                idu_pkg::cls_upper, 5'd10, 32'h1234_5000, 1'b1, 1'b0, 12'h0);
        seq_row(u_type(20'h00010, 5'd11, idu_pkg::opc_auipc),
                idu_pkg::cls_upper, 5'd11, seq_pc + 32'd4 + 32'h0001_0000, 1'b1, 1'b0, 12'h0);
        push_idle();
        jal_row(-64);
        jal_row(2052);
        jalr_row(12'd7, 32'd12);
        jalr_row(12'hFFF, 32'd12);
        branch_row(3'b000, 5'd1, 5'd2, 32, 1'b0);
        branch_row(3'b000, 5'd9, 5'd2, -16, 1'b1);                        // Equal operands
        branch_row(3'b001, 5'd1, 5'd2, 1000, 1'b1);
        branch_row(3'b100, 5'd1, 5'd2, -2000, 1'b1);
        branch_row(3'b101, 5'd1, 5'd2, 8, 1'b0);
        branch_row(3'b110, 5'd1, 5'd2, 4094, 1'b0);
        branch_row(3'b111, 5'd1, 5'd2, -4096, 1'b1);
        push_idle();
        seq_row(i_type(12'd8, 5'd2, 3'b010, 5'd14, idu_pkg::opc_load),
                idu_pkg::cls_load, 5'd14, 32'd20, 1'b0, 1'b0, 12'h0);
        seq_row(s_type(12'hFFC, 5'd1, 5'd2, 3'b010),
                idu_pkg::cls_store, 5'd0, 32'd8, 1'b0, 1'b0, 12'h0);
        seq_row(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd15, idu_pkg::opc_op),
                idu_pkg::cls_muldiv, 5'd15, 32'h0, 1'b0, 1'b0, 12'h0);
        seq_row(i_type(12'h300, 5'd1, 3'b001, 5'd16, idu_pkg::opc_system),
                idu_pkg::cls_system, 5'd16, 32'h0, 1'b0, 1'b0, 12'h300);        // CSRRW
        seq_row(r_type(7'h00, 5'd16, 5'd14, 3'b000, 5'd17, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd17, 32'h0, 1'b1, 1'b0, 12'h0);       // x14, x16 untouched
        seq_row(r_type(7'h10, 5'd2, 5'd1, 3'b000, 5'd18, idu_pkg::opc_op),
                idu_pkg::cls_invalid, 5'd18, 32'h0, 1'b0, 1'b1, 12'h0);
        seq_row(s_type(12'd4, 5'd1, 5'd2, 3'b011),
                idu_pkg::cls_invalid, 5'd0, 32'h0, 1'b0, 1'b1, 12'h0);
        seq_row(32'h0000_007B, idu_pkg::cls_invalid, 5'd0, 32'h0, 1'b0, 1'b1, 12'h0);
        seq_row(r_type(7'h00, 5'd18, 5'd0, 3'b000, 5'd19, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd19, 32'h0, 1'b1, 1'b0, 12'h0);
        seq_row(r_type(7'h00, 5'd4, 5'd3, 3'b000, 5'd20, idu_pkg::opc_op),
                idu_pkg::cls_alu, 5'd20, 32'd19, 1'b1, 1'b0, 12'h0);
    endtask

    task check_class(input string name, input idu_pkg::inst_class_e exp_v,
                     input idu_pkg::inst_class_e act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("ERR %s result %0d: expected %h, got %h", name, res_idx, exp_v, act_v);
        end
    endtask

    task check_word(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("ERR %s result %0d: expected %h, got %h", name, res_idx, exp_v, act_v);
        end
    endtask

    task check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("ERR %s result %0d: expected %h, got %h", name, res_idx, exp_v, act_v);
        end
    endtask

    task check_reg(input string name, input logic [idu_pkg::reg_addr_w-1:0] exp_v,
                   input logic [idu_pkg::reg_addr_w-1:0] act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("ERR %s result %0d: expected %h, got %h", name, res_idx, exp_v, act_v);
        end
    endtask

    task check_csr(input string name, input logic [idu_pkg::csr_addr_w-1:0] exp_v,
                   input logic [idu_pkg::csr_addr_w-1:0] act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("ERR %s result %0d: expected %h, got %h", name, res_idx, exp_v, act_v);
        end
    endtask

    task finish_run();
        $display("Errors: %0d wrong values, %0d missing or extra results", val_errs, seq_errs);
        if (val_errs == 0 && seq_errs == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Outputs settle after the rising edge
    always @(negedge clock) begin
        if (!reset && result.valid) begin
            if (exp_q.size() == 0) begin
                seq_errs++;
                $display("Extra result for pc %h arrived with nothing pending", result.pc);
            end else begin
                exp_row = exp_q.pop_front();
                check_word("result.pc", exp_row.pc, result.pc);
                check_class("result.inst_class", exp_row.cls, result.inst_class);
                if (exp_row.written) begin    // Destination of a real write
                    check_reg("result.rd", exp_row.rd, result.rd);
                end
                check_word("result.wdata", exp_row.wdata, result.wdata);
                check_flag("result.written", exp_row.written, result.written);
                check_flag("result.branch_taken", exp_row.taken, result.branch_taken);
                check_word("result.target", exp_row.target, result.target);
                check_flag("result.invalid", exp_row.invalid, result.invalid);
                check_csr("result.csr_addr", exp_row.csr, result.csr_addr);
                res_idx++;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > limit) begin
            timed_out = 1'b1;
            seq_errs += exp_q.size();
            $display("Timeout after %0d cycles, %0d results never arrived", cycles,
                     exp_q.size());
            finish_run();
        end
    end

    initial begin
        clock      = 1'b0;
        seed       = 9;
        val_errs   = 0;
        seq_errs   = 0;
        res_idx    = 0;
        cycles     = 0;
        timed_out  = 1'b0;
        reset      <= 1'b1;
        inst_valid <= 1'b0;
        pc         <= 32'h0;
        inst       <= 32'h0;
        build_table();
        limit = 3 + 2 * table_q.size() + 20;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        foreach (table_q[i]) begin
            @(posedge clock);
            inst_valid <= !table_q[i].idle;
            pc         <= table_q[i].pc;
            inst       <= table_q[i].inst;
            if (!table_q[i].idle) begin
                exp_q.push_back(table_q[i]);
            end
        end
        @(posedge clock);
        inst_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);    // Room for a stray result
        finish_run();
    end

endmodule
